/* coreDefs.sv */
`default_nettype none

package coreDefs;

    // instruction field widths
    localparam int opW   = 6;
    localparam int regW  = 5;
    localparam int immW  = 16;
    localparam int wordW = 32;

    typedef logic [wordW-1:0] word;
    typedef logic [regW-1:0]  regIdx;
    typedef logic [4:0]       shamt;
    typedef logic [opW-1:0]   opcode;

    // primary opcodes
    localparam opcode opRtype = 6'h00;
    localparam opcode opBeq   = 6'h04;
    localparam opcode opBne   = 6'h05;
    localparam opcode opAddiu = 6'h09;
    localparam opcode opOri   = 6'h0d;
    localparam opcode opLui   = 6'h0f;

    // function field of r-type words
    localparam opcode fnSll  = 6'h00;
    localparam opcode fnAddu = 6'h21;
    localparam opcode fnSubu = 6'h23;
    localparam opcode fnAnd  = 6'h24;
    localparam opcode fnOr   = 6'h25;
    localparam opcode fnXor  = 6'h26;
    localparam opcode fnSlt  = 6'h2a;

    localparam word resetPc = 32'h0000_0000;

    // sll $0, $0, 0
    localparam word nopWord = 32'h0000_0000;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluLui
    } aluOp;

endpackage

`default_nettype wire

/* decodeBus.sv */
`default_nettype none

interface decodeBus import coreDefs::*; ();
    logic  valid;
    word   pc;
    regIdx rs;
    regIdx rt;
    // destination, already chosen between rd and rt
    regIdx rd;
    word   rsVal;
    word   rtVal;
    word   imm;
    shamt  sa;
    aluOp  aluSel;
    logic  useImm;
    logic  regWe;
    logic  isBeq;
    logic  isBne;

    modport src (output valid, pc, rs, rt, rd, rsVal, rtVal, imm,
                 output sa, aluSel, useImm, regWe, isBeq, isBne);

    modport dst (input valid, pc, rs, rt, rd, rsVal, rtVal, imm,
                 input sa, aluSel, useImm, regWe, isBeq, isBne);
endinterface

`default_nettype wire

/* decodeUnit.sv */
`default_nettype none

module decodeUnit import coreDefs::*; (
    input  wire word   instrF,
    input  wire word   pcF,
    input  wire        validF,
    output regIdx      raddrA,
    output regIdx      raddrB,
    input  wire word   rdataA,
    input  wire word   rdataB,
    decodeBus.src      dec
);
    opcode           op;
    opcode           fn;
    regIdx           rsF;
    regIdx           rtF;
    regIdx           rdF;
    regIdx           dest;
    logic [immW-1:0] imm16;
    aluOp            sel;
    logic            useImm;
    logic            writes;
    logic            toRt;
    logic            zeroExt;
    logic            isBeq;
    logic            isBne;

    assign op    = instrF[31:26];
    assign rsF   = instrF[25:21];
    assign rtF   = instrF[20:16];
    assign rdF   = instrF[15:11];
    assign fn    = instrF[5:0];
    assign imm16 = instrF[immW-1:0];

    always_comb begin
        sel     = aluAdd;
        useImm  = 1'b0;
        writes  = 1'b0;
        toRt    = 1'b0;
        zeroExt = 1'b0;
        isBeq   = 1'b0;
        isBne   = 1'b0;
        case (op)
            opRtype: begin
                writes = 1'b1;
                case (fn)
                    fnAddu:  sel = aluAdd;
                    fnSubu:  sel = aluSub;
                    fnAnd:   sel = aluAnd;
                    fnOr:    sel = aluOr;
                    fnXor:   sel = aluXor;
                    fnSlt:   sel = aluSlt;
                    fnSll:   sel = aluSll;
                    default: writes = 1'b0;
                endcase
            end
            opAddiu: begin
                useImm = 1'b1;
                writes = 1'b1;
                toRt   = 1'b1;
            end
            opOri: begin
                sel     = aluOr;
                useImm  = 1'b1;
                writes  = 1'b1;
                toRt    = 1'b1;
                zeroExt = 1'b1;
            end
            opLui: begin
                sel    = aluLui;
                useImm = 1'b1;
                writes = 1'b1;
                toRt   = 1'b1;
            end
            opBeq:   isBeq = 1'b1;
            opBne:   isBne = 1'b1;
            // anything else retires as a no-op
            default: writes = 1'b0;
        endcase
    end

    assign dest   = toRt ? rtF : rdF;
    assign raddrA = rsF;
    assign raddrB = rtF;

    assign dec.valid  = validF;
    assign dec.pc     = pcF;
    assign dec.rs     = rsF;
    assign dec.rt     = rtF;
    assign dec.rd     = dest;
    assign dec.rsVal  = rdataA;
    assign dec.rtVal  = rdataB;
    assign dec.imm    = zeroExt ? {{(wordW-immW){1'b0}}, imm16}
                                : {{(wordW-immW){imm16[immW-1]}}, imm16};
    assign dec.sa     = instrF[10:6];
    assign dec.aluSel = sel;
    assign dec.useImm = useImm;
    assign dec.regWe  = writes && (dest != '0);
    assign dec.isBeq  = isBeq;
    assign dec.isBne  = isBne;

endmodule

`default_nettype wire

/* executeUnit.sv */
`default_nettype none

module executeUnit import coreDefs::*; (
    input  wire        clk,
    input  wire        rstN,
    input  wire        stallE,
    decodeBus.dst      ex,
    input  wire        fwdA,
    input  wire        fwdB,
    output logic       branchTaken,
    output word        branchTarget,
    output logic       wbRegWe,
    output logic       retireValid,
    output word        retirePc,
    output logic       retireWe,
    output regIdx      retireReg,
    output word        retireData,
    input  wire        retireReady
);
    word  opA;
    word  opB;
    word  rtFwd;
    word  aluRes;
    logic same;

    // writeback result bypasses the stale register values
    assign opA   = fwdA ? retireData : ex.rsVal;
    assign rtFwd = fwdB ? retireData : ex.rtVal;
    assign opB   = ex.useImm ? ex.imm : rtFwd;

    always_comb begin
        case (ex.aluSel)
            aluAdd:  aluRes = opA + opB;
            aluSub:  aluRes = opA - opB;
            aluAnd:  aluRes = opA & opB;
            aluOr:   aluRes = opA | opB;
            aluXor:  aluRes = opA ^ opB;
            aluSlt:  aluRes = {{(wordW-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSll:  aluRes = opB << ex.sa;
            aluLui:  aluRes = {opB[immW-1:0], {immW{1'b0}}};
            default: aluRes = '0;
        endcase
    end

    // branches compare rs with rt, never with the immediate
    assign same         = (opA == rtFwd);
    assign branchTaken  = ex.valid && ((ex.isBeq && same) || (ex.isBne && !same));
    assign branchTarget = ex.pc + 32'd4 + {ex.imm[wordW-3:0], 2'b00};

    // writeback stage, presented directly as the retire port
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retireValid <= 1'b0;
            retireWe    <= 1'b0;
        end else if (!stallE) begin
            retireValid <= ex.valid;
            retireWe    <= ex.valid && ex.regWe;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallE) begin
            retirePc   <= ex.pc;
            retireReg  <= ex.rd;
            retireData <= aluRes;
        end
    end

    // register file only changes on an accepted retire
    assign wbRegWe = retireValid && retireReady && retireWe;

    retireHeld: assert property (@(posedge clk) disable iff (!rstN)
        retireValid && !retireReady |=>
            retireValid && $stable({retirePc, retireWe, retireReg, retireData}));

endmodule

`default_nettype wire

/* fetchUnit.sv */
`default_nettype none

module fetchUnit import coreDefs::*; (
    input  wire        clk,
    input  wire        rstN,
    output logic       wbCyc,
    output logic       wbStb,
    output logic       wbWe,
    output word        wbAdr,
    input  wire word   wbDatI,
    input  wire        wbAck,
    input  wire        stallE,
    input  wire        flushE,
    input  wire        branchTaken,
    input  wire word   branchTarget,
    output word        instrF,
    output word        pcF,
    output logic       validF
);
    typedef enum logic [1:0] {fsIdle, fsBusy, fsDiscard} fetchState;

    fetchState state;
    word       pc;
    word       adr;
    logic      canTake;
    logic      redirect;

    // register can fill unless it holds a word that decode cannot pass on
    assign canTake  = !(validF && stallE);
    assign redirect = flushE && branchTaken;

    assign wbCyc = (state != fsIdle);
    assign wbStb = wbCyc;
    assign wbWe  = 1'b0;
    assign wbAdr = adr;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= fsIdle;
            pc    <= resetPc;
            adr   <= resetPc;
        end else begin
            case (state)
                fsIdle: begin
                    if (redirect) begin
                        pc <= branchTarget;
                    end else if (canTake) begin
                        adr   <= pc;
                        state <= fsBusy;
                    end
                end
                fsBusy: begin
                    if (redirect) begin
                        pc    <= branchTarget;
                        state <= wbAck ? fsIdle : fsDiscard;
                    end else if (wbAck) begin
                        // a blocked word is simply fetched again later
                        if (canTake) begin
                            pc <= adr + 32'd4;
                        end
                        state <= fsIdle;
                    end
                end
                fsDiscard: begin
                    if (redirect) begin
                        pc <= branchTarget;
                    end
                    if (wbAck) begin
                        state <= fsIdle;
                    end
                end
                default: state <= fsIdle;
            endcase
        end
    end

    // fetch/decode register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validF <= 1'b0;
            instrF <= nopWord;
            pcF    <= resetPc;
        end else if (flushE) begin
            validF <= 1'b0;
            instrF <= nopWord;
        end else if (state == fsBusy && wbAck && canTake) begin
            validF <= 1'b1;
            instrF <= wbDatI;
            pcF    <= adr;
        end else if (!stallE) begin
            // word moved on into decode
            validF <= 1'b0;
        end
    end

    // classic cycle keeps its request and address until ack
    adrHeld: assert property (@(posedge clk) disable iff (!rstN)
        wbStb && !wbAck |=> wbStb && $stable(wbAdr));

endmodule

`default_nettype wire

/* hazardUnit.sv */
`default_nettype none

module hazardUnit import coreDefs::*; (
    input  wire        wbValid,
    input  wire        wbWe,
    input  wire regIdx wbReg,
    input  wire regIdx exRs,
    input  wire regIdx exRt,
    input  wire        retireReady,
    input  wire        branchTaken,
    output logic       stallE,
    output logic       flushE,
    output logic       fwdA,
    output logic       fwdB
);
    logic wbWrites;

    // retire port back-pressure freezes everything behind writeback
    assign stallE = wbValid && !retireReady;

    // redirect only once the branch is free to move on
    assign flushE = branchTaken && !stallE;

    // r0 is never forwarded
    assign wbWrites = wbValid && wbWe && (wbReg != '0);
    assign fwdA     = wbWrites && (wbReg == exRs);
    assign fwdB     = wbWrites && (wbReg == exRt);

endmodule

`default_nettype wire

/* idExReg.sv */
`default_nettype none

module idExReg import coreDefs::*; (
    input  wire   clk,
    input  wire   rstN,
    input  wire   stallE,
    input  wire   flushE,
    decodeBus.dst d,
    decodeBus.src e
);
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            e.valid  <= 1'b0;
            e.pc     <= '0;
            e.rs     <= '0;
            e.rt     <= '0;
            e.rd     <= '0;
            e.rsVal  <= '0;
            e.rtVal  <= '0;
            e.imm    <= '0;
            e.sa     <= '0;
            e.aluSel <= aluAdd;
            e.useImm <= 1'b0;
            e.regWe  <= 1'b0;
            e.isBeq  <= 1'b0;
            e.isBne  <= 1'b0;
        end else if (flushE) begin
            // squashed slot becomes a bubble
            e.valid  <= 1'b0;
            e.pc     <= '0;
            e.rs     <= '0;
            e.rt     <= '0;
            e.rd     <= '0;
            e.rsVal  <= '0;
            e.rtVal  <= '0;
            e.imm    <= '0;
            e.sa     <= '0;
            e.aluSel <= aluAdd;
            e.useImm <= 1'b0;
            e.regWe  <= 1'b0;
            e.isBeq  <= 1'b0;
            e.isBne  <= 1'b0;
        end else if (!stallE) begin
            e.valid  <= d.valid;
            e.pc     <= d.pc;
            e.rs     <= d.rs;
            e.rt     <= d.rt;
            e.rd     <= d.rd;
            e.rsVal  <= d.rsVal;
            e.rtVal  <= d.rtVal;
            e.imm    <= d.imm;
            e.sa     <= d.sa;
            e.aluSel <= d.aluSel;
            e.useImm <= d.useImm;
            e.regWe  <= d.regWe;
            e.isBeq  <= d.isBeq;
            e.isBne  <= d.isBne;
        end
    end

    // a held branch must not redirect fetch
    noStallFlush: assert property (@(posedge clk) disable iff (!rstN) !(stallE && flushE));

endmodule

`default_nettype wire

/* miniCore.f */
coreDefs.sv
decodeBus.sv
fetchUnit.sv
regFile.sv
decodeUnit.sv
idExReg.sv
executeUnit.sv
hazardUnit.sv
miniCore.sv
tbWishboneRom.sv
tbMiniCore.sv

/* miniCore.sv */
`default_nettype none

module miniCore import coreDefs::*; (
    input  wire        clk,
    input  wire        rstN,
    output logic       wbCyc,
    output logic       wbStb,
    output logic       wbWe,
    output word        wbAdr,
    input  wire word   wbDatI,
    input  wire        wbAck,
    output logic       retireValid,
    input  wire        retireReady,
    output word        retirePc,
    output logic       retireWe,
    output regIdx      retireReg,
    output word        retireData
);
    word   instrF;
    word   pcF;
    logic  validF;
    regIdx raddrA;
    regIdx raddrB;
    word   rdataA;
    word   rdataB;
    logic  stallE;
    logic  flushE;
    logic  fwdA;
    logic  fwdB;
    logic  branchTaken;
    word   branchTarget;
    logic  wbRegWe;

    decodeBus idBus ();
    decodeBus exBus ();

    fetchUnit uFetch (
        .clk(clk), .rstN(rstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatI(wbDatI), .wbAck(wbAck),
        .stallE(stallE), .flushE(flushE),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .instrF(instrF), .pcF(pcF), .validF(validF)
    );

    regFile uRegs (
        .clk(clk), .rstN(rstN),
        .raddrA(raddrA), .raddrB(raddrB), .rdataA(rdataA), .rdataB(rdataB),
        .we(wbRegWe), .waddr(retireReg), .wdata(retireData)
    );

    decodeUnit uDecode (
        .instrF(instrF), .pcF(pcF), .validF(validF),
        .raddrA(raddrA), .raddrB(raddrB), .rdataA(rdataA), .rdataB(rdataB),
        .dec(idBus.src)
    );

    idExReg uIdEx (
        .clk(clk), .rstN(rstN), .stallE(stallE), .flushE(flushE),
        .d(idBus.dst), .e(exBus.src)
    );

    executeUnit uExec (
        .clk(clk), .rstN(rstN), .stallE(stallE), .ex(exBus.dst),
        .fwdA(fwdA), .fwdB(fwdB),
        .branchTaken(branchTaken), .branchTarget(branchTarget), .wbRegWe(wbRegWe),
        .retireValid(retireValid), .retirePc(retirePc), .retireWe(retireWe),
        .retireReg(retireReg), .retireData(retireData), .retireReady(retireReady)
    );

    hazardUnit uHazard (
        .wbValid(retireValid), .wbWe(retireWe), .wbReg(retireReg),
        .exRs(exBus.rs), .exRt(exBus.rt),
        .retireReady(retireReady), .branchTaken(branchTaken),
        .stallE(stallE), .flushE(flushE), .fwdA(fwdA), .fwdB(fwdB)
    );

endmodule

`default_nettype wire

/* regFile.sv */
`default_nettype none

module regFile import coreDefs::*; (
    input  wire        clk,
    input  wire        rstN,
    input  wire regIdx raddrA,
    input  wire regIdx raddrB,
    output word        rdataA,
    output word        rdataB,
    input  wire        we,
    input  wire regIdx waddr,
    input  wire word   wdata
);
    word regs [2**regW];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**regW; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads zero, a write in flight is seen by decode at once
    assign rdataA = (raddrA == '0) ? '0 :
                    (we && waddr == raddrA) ? wdata : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 :
                    (we && waddr == raddrB) ? wdata : regs[raddrB];

endmodule

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbMiniCore -f miniCore.f -o simMiniCore
if [ $? -ne 0 ]; then
    echo "runSim: verilator build failed"
    exit 1
fi

./obj_dir/simMiniCore > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "runSim: simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
echo "runSim: pass message not found in sim.log"
exit 1

/* tbMiniCore.sv */
`default_nettype none

module tbMiniCore import coreDefs::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int progLen   = 26;
    localparam int expLen    = 25;
    localparam int waitLimit = 200;

    logic  clk;
    logic  rstN;
    logic  wbCyc;
    logic  wbStb;
    logic  wbWe;
    word   wbAdr;
    word   wbDatI;
    logic  wbAck;
    logic  retireValid;
    logic  retireReady;
    word   retirePc;
    logic  retireWe;
    regIdx retireReg;
    word   retireData;

    // program at address 0, one word per entry
    word progTable [progLen] = '{
        32'h3c011234, 32'h34215678, 32'h2402fffd, 32'h00221821,
        32'h00612023, 32'h00232824, 32'h00a23025, 32'h00c13826,
        32'h0041402a, 32'h00084900, 32'h0022502a, 32'h252b0001,
        32'h11400002, 32'h240c0111, 32'h240d0222, 32'h15690002,
        32'h240c0333, 32'h240d0444, 32'h11690005, 32'h14210005,
        32'h016b6021, 32'h018c6021, 32'h018b6823, 32'h00210021,
        32'h01a07025, 32'h1000ffff
    };

    // expected retires, worked out by hand; last four are the self loop
    word expPc [expLen] = '{
        32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h14, 32'h18, 32'h1c,
        32'h20, 32'h24, 32'h28, 32'h2c, 32'h30, 32'h3c, 32'h48, 32'h4c,
        32'h50, 32'h54, 32'h58, 32'h5c, 32'h60, 32'h64, 32'h64, 32'h64,
        32'h64
    };
    bit expWe [expLen] = '{
        1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 0, 0, 0, 0,
        1, 1, 1, 0, 1, 0, 0, 0, 0
    };
    regIdx expReg [expLen] = '{
        5'd1, 5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7,
        5'd8, 5'd9, 5'd10, 5'd11, 5'd0, 5'd0, 5'd0, 5'd0,
        5'd12, 5'd12, 5'd13, 5'd0, 5'd14, 5'd0, 5'd0, 5'd0, 5'd0
    };
    word expData [expLen] = '{
        32'h12340000, 32'h12345678, 32'hfffffffd, 32'h12345675,
        32'hfffffffd, 32'h12345670, 32'hfffffffd, 32'hedcba985,
        32'h00000001, 32'h00000010, 32'h00000000, 32'h00000011,
        32'h0, 32'h0, 32'h0, 32'h0,
        32'h00000022, 32'h00000044, 32'h00000033, 32'h0,
        32'h00000033, 32'h0, 32'h0, 32'h0, 32'h0
    };

    int          checks;
    int          valueErrors;
    int          timeouts;
    logic [31:0] rngState;
    logic        heldValid;
    logic [69:0] heldSnap;

    miniCore DUT (
        .clk(clk), .rstN(rstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatI(wbDatI), .wbAck(wbAck),
        .retireValid(retireValid), .retireReady(retireReady),
        .retirePc(retirePc), .retireWe(retireWe),
        .retireReg(retireReg), .retireData(retireData)
    );

    tbWishboneRom uRom (
        .clk(clk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatI(wbDatI), .wbAck(wbAck)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic applyReset();
        int cycles;
        rstN        = 1'b0;
        retireReady = 1'b1;
        heldValid   = 1'b0;
        repeat (16) begin
            @(negedge clk);
            checks++;
            assert (!wbCyc && !wbStb && !retireValid) else begin
                valueErrors++;
                $display("Fail in reset: wbCyc %h wbStb %h retireValid %h",
                         wbCyc, wbStb, retireValid);
            end
        end
        rstN   = 1'b1;
        cycles = 0;
        // first request must come from the reset address
        while (!wbCyc && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
            checks++;
            assert (!retireValid) else begin
                valueErrors++;
                $display("Fail before first fetch: retireValid %h", retireValid);
            end
        end
        if (!wbCyc) begin
            timeouts++;
            $display("timeout: no fetch request after reset");
        end else begin
            checks++;
            assert (wbAdr == resetPc) else begin
                valueErrors++;
                $display("Fail first wbAdr: got %h expected %h", wbAdr, resetPc);
            end
        end
    endtask

    // one falling edge per step; ready is redrawn on every step
    task automatic awaitRetire(input bit randomReady, output bit seen);
        int          cycles;
        logic [69:0] now;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
            now = {retirePc, retireWe, retireReg, retireData};
            // read-only classic master, strobe rides with the cycle
            checks++;
            assert (wbStb == wbCyc && !wbWe) else begin
                valueErrors++;
                $display("Fail wishbone request: wbCyc %h wbStb %h wbWe %h",
                         wbCyc, wbStb, wbWe);
            end
            if (heldValid) begin
                checks++;
                assert (retireValid && now == heldSnap) else begin
                    valueErrors++;
                    $display("Fail retire outputs while held: got %h expected %h",
                             now, heldSnap);
                end
            end
            if (randomReady) begin
                rngState    = xorshift32(rngState);
                retireReady = rngState[4];
            end else begin
                retireReady = 1'b1;
            end
            heldValid = retireValid && !retireReady;
            heldSnap  = now;
            seen      = retireValid && retireReady;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: no retire handshake within %0d cycles", waitLimit);
        end
    endtask

    task automatic checkRetire(input int idx);
        checks++;
        assert (retirePc == expPc[idx]) else begin
            valueErrors++;
            $display("Fail retirePc entry %0d: got %h expected %h", idx, retirePc, expPc[idx]);
        end
        assert (retireWe == expWe[idx]) else begin
            valueErrors++;
            $display("Fail retireWe entry %0d: got %h expected %h", idx, retireWe, expWe[idx]);
        end
        // reg and data only matter for a register write
        if (expWe[idx]) begin
            assert (retireReg == expReg[idx]) else begin
                valueErrors++;
                $display("Fail retireReg entry %0d: got %h expected %h",
                         idx, retireReg, expReg[idx]);
            end
            assert (retireData == expData[idx]) else begin
                valueErrors++;
                $display("Fail retireData entry %0d: got %h expected %h",
                         idx, retireData, expData[idx]);
            end
        end
    endtask

    task automatic runProgram(input bit randomReady);
        bit seen;
        applyReset();
        for (int i = 0; i < expLen; i++) begin
            awaitRetire(randomReady, seen);
            if (!seen) begin
                break;
            end
            checkRetire(i);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        retireReady = 1'b0;
        heldValid   = 1'b0;
        heldSnap    = '0;
        checks      = 0;
        valueErrors = 0;
        timeouts    = 0;
        rngState    = 32'h582f_ff8e;
        for (int i = 0; i < 32; i++) begin
            if (i < progLen) begin
                uRom.mem[i] = progTable[i];
            end else begin
                uRom.mem[i] = {16'h2400, 16'(i * 4)};
            end
        end
        // always ready first, then random back-pressure
        runProgram(1'b0);
        runProgram(1'b1);
        $display("checks %0d, value errors %0d, timeouts %0d", checks, valueErrors, timeouts);
        if (valueErrors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tbWishboneRom.sv */
`default_nettype none

module tbWishboneRom import coreDefs::*; (
    input  wire      clk,
    input  wire      rstN,
    input  wire      wbCyc,
    input  wire      wbStb,
    input  wire      wbWe,
    input  wire word wbAdr,
    output word      wbDatI,
    output logic     wbAck
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int romWords = 32;

    // filled by the testbench top before reset is released
    word         mem [romWords];
    logic [31:0] rngState;
    logic [1:0]  delay;
    logic [1:0]  waitCnt;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        rngState = 32'h582f_ff8e;
        delay    = 2'd0;
    end

    // responses change on the falling edge, like every other DUT input
    // a write request is never acknowledged
    always @(negedge clk or negedge rstN) begin
        if (!rstN) begin
            wbAck   <= 1'b0;
            wbDatI  <= '0;
            waitCnt <= 2'd0;
        end else if (wbCyc && wbStb && !wbWe && !wbAck) begin
            if (waitCnt == delay) begin
                wbAck    <= 1'b1;
                // past the table, return addiu $0 tagged with the address
                wbDatI   <= (wbAdr[31:7] == '0) ? mem[wbAdr[6:2]]
                                                : {16'h2400, wbAdr[31:16] ^ wbAdr[15:0]};
                waitCnt  <= 2'd0;
                rngState <= xorshift32(rngState);
                delay    <= rngState[1:0];
            end else begin
                waitCnt <= waitCnt + 2'd1;
            end
        end else begin
            wbAck <= 1'b0;
        end
    end

endmodule

`default_nettype wire
